/* sources.f */
+incdir+include
design/dnc_pkg.sv
design/dnc_vector_if.sv
design/dnc_write_key.sv
design/dnc_memory_rows.sv
design/dnc_content_score.sv
design/dnc_write_content.sv
tests/dnc_write_content_assertions.sv
tests/dnc_write_content_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the content-addressing testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=dnc_write_content_tb
OBJ_DIR=obj_dir
LOG=sim.log

# Compile
verilator --binary --timing --assert -j 0 \
  --top-module "$TOP" --Mdir "$OBJ_DIR" -o "$TOP" -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Run into the log
"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict from the log
if grep -q "TEST FAILED" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi
exit 0

/* tests/dnc_write_content_tb.sv */
/*
  Testbench for the content-addressing write head front end
  Loads the row store, runs a table of requests and checks each score
  against a dot product computed from a local copy of memory and key
*/
`timescale 1ns/1ps
`default_nettype none

`include "dnc_defaults.svh"

module dnc_write_content_tb;

  import dnc_pkg::*;

  localparam int DATA_SIZE  = `DNC_DATA_SIZE;
  localparam int SIZE_N     = `DNC_SIZE_N;
  localparam int SIZE_W     = `DNC_SIZE_W;
  localparam int ROW_BITS   = $clog2(SIZE_N);
  localparam int SCORE_SIZE = 2 * DATA_SIZE + ACC_GUARD;
  localparam int TIMEOUT    = 200;
  localparam int NUM_CASES  = 8;
  // Row filled with signed extremes
  localparam int EXT_ROW    = SIZE_N - 1;

  localparam logic [31:0]          SEED    = 32'h0fc4_3478;
  localparam logic [DATA_SIZE-1:0] MAX_POS = {1'b0, {(DATA_SIZE-1){1'b1}}};
  localparam logic [DATA_SIZE-1:0] MAX_NEG = {1'b1, {(DATA_SIZE-1){1'b0}}};

  ////////////////////
  // Case table
  ////////////////////

  typedef struct packed {
    logic [7:0] row;
    logic [7:0] w;
    logic       gaps;
    logic       extreme;
    logic       reuse;
    logic [3:0] delay;
    logic       mid_write;
  } case_t;

  // row, W, key gaps, extreme key, reuse key, score_ready delay, write in flight
  localparam case_t CASES [NUM_CASES] = '{
    '{8'd0, 8'd8, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0},
    '{8'd0, 8'd8, 1'b1, 1'b0, 1'b1, 4'd0, 1'b0},
    '{8'd3, 8'd1, 1'b0, 1'b0, 1'b0, 4'd3, 1'b0},
    '{8'd5, 8'd4, 1'b1, 1'b0, 1'b0, 4'd5, 1'b1},
    '{8'd5, 8'd4, 1'b0, 1'b0, 1'b1, 4'd0, 1'b0},
    '{8'd7, 8'd8, 1'b0, 1'b1, 1'b0, 4'd2, 1'b0},
    '{8'd2, 8'd8, 1'b1, 1'b0, 1'b0, 4'd1, 1'b0},
    '{8'd6, 8'd5, 1'b0, 1'b0, 1'b0, 4'd4, 1'b0}
  };

  ////////////////////
  // Signals
  ////////////////////

  logic                  CLK;
  logic                  RST;
  logic                  mem_wr_valid;
  logic                  mem_wr_ready;
  logic [ROW_BITS-1:0]   mem_wr_row;
  logic [CNT_SIZE-1:0]   mem_wr_col;
  logic [DATA_SIZE-1:0]  mem_wr_data;
  logic                  start_valid;
  logic                  start_ready;
  logic [ROW_BITS-1:0]   start_row;
  logic [CNT_SIZE-1:0]   size_w;
  logic                  key_valid;
  logic                  key_ready;
  logic [DATA_SIZE-1:0]  key_data;
  logic                  score_valid;
  logic                  score_ready;
  logic [SCORE_SIZE-1:0] score_data;

  // Reference state
  logic [31:0]                 lfsr_state;
  logic signed [DATA_SIZE-1:0] ref_mem [SIZE_N][SIZE_W];
  logic signed [DATA_SIZE-1:0] key_buf [SIZE_W];
  int                          gap_len [SIZE_W];

  dnc_write_content #(
    .DATA_SIZE(DATA_SIZE),
    .SIZE_N   (SIZE_N),
    .SIZE_W   (SIZE_W)
  ) dnc_write_content_inst (
    .CLK         (CLK),
    .RST         (RST),
    .mem_wr_valid(mem_wr_valid),
    .mem_wr_ready(mem_wr_ready),
    .mem_wr_row  (mem_wr_row),
    .mem_wr_col  (mem_wr_col),
    .mem_wr_data (mem_wr_data),
    .start_valid (start_valid),
    .start_ready (start_ready),
    .start_row   (start_row),
    .size_w      (size_w),
    .key_valid   (key_valid),
    .key_ready   (key_ready),
    .key_data    (key_data),
    .score_valid (score_valid),
    .score_ready (score_ready),
    .score_data  (score_data)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  ////////////////////
  // Helpers
  ////////////////////

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < count; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  // Signed products summed wide, then cut to the score width
  function automatic logic [SCORE_SIZE-1:0] dot_product(input int row, input int w);
    longint sum;
    sum = 0;
    for (int i = 0; i < w; i++) begin
      sum += longint'(key_buf[i]) * longint'(ref_mem[row][i]);
    end
    return sum[SCORE_SIZE-1:0];
  endfunction

  task automatic stop_failed();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
    stop_failed();
  endtask

  task automatic check_score(input string name, input logic [SCORE_SIZE-1:0] actual,
                             input logic [SCORE_SIZE-1:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s got %h expected %h", name, actual, expected);
      stop_failed();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("ERROR %s got %h expected %h", name, actual, expected);
      stop_failed();
    end
  endtask

  ////////////////////
  // Bus tasks
  ////////////////////

  // Entered and left 2 ns after a rising edge
  task automatic write_element(input logic [ROW_BITS-1:0] row, input logic [CNT_SIZE-1:0] col,
                               input logic [DATA_SIZE-1:0] data, input logic after_score);
    int cycles;
    cycles       = 0;
    mem_wr_row   = row;
    mem_wr_col   = col;
    mem_wr_data  = data;
    mem_wr_valid = 1'b1;
    @(negedge CLK);
    while (!mem_wr_ready) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("mem_wr_ready");
      @(negedge CLK);
    end
    // Write in flight opens only with the score
    if (after_score) check_flag("score_valid", score_valid, 1'b1);
    @(posedge CLK);
    #2;
    mem_wr_valid = 1'b0;
  endtask

  task automatic issue_start(input logic [ROW_BITS-1:0] row, input logic [CNT_SIZE-1:0] w);
    int cycles;
    cycles      = 0;
    start_row   = row;
    size_w      = w;
    start_valid = 1'b1;
    @(negedge CLK);
    while (!start_ready) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("start_ready");
      @(negedge CLK);
    end
    @(posedge CLK);
    #2;
    start_valid = 1'b0;
  endtask

  task automatic send_key(input int w, input logic gaps);
    int cycles;
    for (int i = 0; i < w; i++) begin
      if (gaps) begin
        repeat (gap_len[i]) begin
          @(posedge CLK);
          #2;
        end
      end
      key_data  = key_buf[i];
      key_valid = 1'b1;
      cycles    = 0;
      @(negedge CLK);
      while (!key_ready) begin
        cycles++;
        if (cycles > TIMEOUT) report_timeout("key_ready");
        @(negedge CLK);
      end
      @(posedge CLK);
      #2;
      key_valid = 1'b0;
    end
    // Offer one more element, must be refused
    key_valid = 1'b1;
    key_data  = '0;
    repeat (2) begin
      @(negedge CLK);
      check_flag("key_ready", key_ready, 1'b0);
    end
    @(posedge CLK);
    #2;
    key_valid = 1'b0;
  endtask

  task automatic collect_score(input logic [SCORE_SIZE-1:0] expected, input int delay);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!score_valid) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("score_valid");
      @(negedge CLK);
    end
    check_score("score_data", score_data, expected);
    // Back-pressure, score must hold
    repeat (delay) begin
      check_flag("start_ready", start_ready, 1'b0);
      @(negedge CLK);
      check_flag("score_valid", score_valid, 1'b1);
      check_score("score_data", score_data, expected);
    end
    check_flag("start_ready", start_ready, 1'b0);
    @(posedge CLK);
    #2;
    score_ready = 1'b1;
    @(posedge CLK);
    #2;
    score_ready = 1'b0;
  endtask

  ////////////////////
  // Sequences
  ////////////////////

  task automatic load_memory();
    logic [DATA_SIZE-1:0] value;
    for (int r = 0; r < SIZE_N; r++) begin
      for (int c = 0; c < SIZE_W; c++) begin
        if (r == EXT_ROW) begin
          value = (c % 2 == 1) ? MAX_POS : MAX_NEG;
        end else begin
          value = DATA_SIZE'(rand_bits(DATA_SIZE));
        end
        ref_mem[r][c] = value;
        write_element(ROW_BITS'(r), CNT_SIZE'(c), value, 1'b0);
      end
    end
  endtask

  task automatic run_case(input case_t tc);
    logic [SCORE_SIZE-1:0] expected;
    logic [DATA_SIZE-1:0]  new_elem;
    int                    w;
    w = int'(tc.w);
    if (!tc.reuse) begin
      for (int i = 0; i < w; i++) begin
        if (tc.extreme) begin
          key_buf[i] = (i % 2 == 1) ? MAX_NEG : MAX_POS;
        end else begin
          key_buf[i] = DATA_SIZE'(rand_bits(DATA_SIZE));
        end
      end
    end
    // Drawn up front so the parallel threads take no random bits
    for (int i = 0; i < w; i++) begin
      gap_len[i] = int'(rand_bits(2));
    end
    new_elem = DATA_SIZE'(rand_bits(DATA_SIZE));
    // Row is read before any write in flight lands
    expected = dot_product(int'(tc.row), w);
    issue_start(ROW_BITS'(tc.row), tc.w);
    fork
      send_key(w, tc.gaps);
      collect_score(expected, int'(tc.delay));
      if (tc.mid_write) begin
        write_element(ROW_BITS'(tc.row), '0, new_elem, 1'b1);
        ref_mem[int'(tc.row)][0] = new_elem;
      end
    join
    // Score taken, ready for the next request
    @(negedge CLK);
    check_flag("score_valid", score_valid, 1'b0);
    check_flag("start_ready", start_ready, 1'b1);
    @(posedge CLK);
    #2;
  endtask

  ////////////////////
  // Main
  ////////////////////

  initial begin
    int cycles;
    CLK          = 1'b0;
    RST          = 1'b1;
    mem_wr_valid = 1'b0;
    mem_wr_row   = '0;
    mem_wr_col   = '0;
    mem_wr_data  = '0;
    start_valid  = 1'b0;
    start_row    = '0;
    size_w       = '0;
    key_valid    = 1'b0;
    key_data     = '0;
    score_ready  = 1'b0;
    lfsr_state   = SEED;

    repeat (3) @(posedge CLK);
    #2;
    RST = 1'b0;

    // Quiet straight out of reset
    @(negedge CLK);
    check_flag("score_valid", score_valid, 1'b0);
    check_flag("start_ready", start_ready, 1'b0);
    check_flag("mem_wr_ready", mem_wr_ready, 1'b0);
    check_flag("key_ready", key_ready, 1'b0);
    cycles = 0;
    while (!(start_ready && mem_wr_ready)) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("start_ready and mem_wr_ready after reset");
      @(negedge CLK);
    end
    @(posedge CLK);
    #2;

    load_memory();
    for (int n = 0; n < NUM_CASES; n++) begin
      run_case(CASES[n]);
    end

    // Bound protocol checks
    if (dnc_write_content_inst.dnc_write_content_assertions_inst.fail_count != 0) begin
      $display("Protocol assertions failed %0d times",
               dnc_write_content_inst.dnc_write_content_assertions_inst.fail_count);
      stop_failed();
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tests/dnc_write_content_assertions.sv */
/*
  Protocol checks for the write head front end
  Score hold, request lockout and memory write lockout
*/
`timescale 1ns/1ps
`default_nettype none

module dnc_write_content_assertions #(
  parameter int DATA_SIZE = 16
) (
  input wire                                       CLK,
  input wire                                       RST,
  input wire                                       start_valid,
  input wire                                       start_ready,
  input wire                                       mem_wr_ready,
  input wire                                       score_valid,
  input wire                                       score_ready,
  input wire [2*DATA_SIZE+dnc_pkg::ACC_GUARD-1:0]  score_data
);

  // Set by a start transfer, cleared once the score shows
  logic in_flight;

  // Number of failed properties
  int fail_count = 0;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      in_flight <= 1'b0;
    end else if (start_valid && start_ready) begin
      in_flight <= 1'b1;
    end else if (score_valid) begin
      in_flight <= 1'b0;
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  // Held score must not move
  score_held: assert property (@(posedge CLK) disable iff (RST)
    (score_valid && !score_ready) |=> $stable(score_data))
    else begin
      fail_count++;
      $error("score_data changed while waiting for score_ready");
    end

  // No new request while a score is pending
  start_locked: assert property (@(posedge CLK) disable iff (RST)
    score_valid |-> !start_ready)
    else begin
      fail_count++;
      $error("start_ready high while score_valid is high");
    end

  // Row store closed for writes during a request
  write_locked: assert property (@(posedge CLK) disable iff (RST)
    (in_flight && !score_valid) |-> !mem_wr_ready)
    else begin
      fail_count++;
      $error("mem_wr_ready high while a request is in flight");
    end

endmodule

bind dnc_write_content dnc_write_content_assertions #(
  .DATA_SIZE(DATA_SIZE)
) dnc_write_content_assertions_inst (
  .CLK         (CLK),
  .RST         (RST),
  .start_valid (start_valid),
  .start_ready (start_ready),
  .mem_wr_ready(mem_wr_ready),
  .score_valid (score_valid),
  .score_ready (score_ready),
  .score_data  (score_data)
);

`default_nettype wire

/* design/dnc_write_content.sv */
/*
  Content-addressing write head front end
  Key streamer, row store and scorer joined by two element streams
*/
`timescale 1ns/1ps
`default_nettype none

`include "dnc_defaults.svh"

module dnc_write_content #(
  parameter int DATA_SIZE = `DNC_DATA_SIZE,
  parameter int SIZE_N    = `DNC_SIZE_N,
  parameter int SIZE_W    = `DNC_SIZE_W
) (
  input  wire                                       CLK,
  input  wire                                       RST,

  // Memory write
  input  wire                                       mem_wr_valid,
  output logic                                      mem_wr_ready,
  input  wire  [$clog2(SIZE_N)-1:0]                 mem_wr_row,
  input  wire  [dnc_pkg::CNT_SIZE-1:0]              mem_wr_col,
  input  wire  [DATA_SIZE-1:0]                      mem_wr_data,

  // Request
  input  wire                                       start_valid,
  output logic                                      start_ready,
  input  wire  [$clog2(SIZE_N)-1:0]                 start_row,
  input  wire  [dnc_pkg::CNT_SIZE-1:0]              size_w,

  // Key stream
  input  wire                                       key_valid,
  output logic                                      key_ready,
  input  wire  [DATA_SIZE-1:0]                      key_data,

  // Score
  output logic                                      score_valid,
  input  wire                                       score_ready,
  output logic [2*DATA_SIZE+dnc_pkg::ACC_GUARD-1:0] score_data
);

  import dnc_pkg::*;

  ////////////////////
  // Internal wiring
  ////////////////////

  logic                      begin_pulse;
  logic [CNT_SIZE-1:0]       size_w_req;
  logic [$clog2(SIZE_N)-1:0] row_sel;

  // Key and row element streams
  dnc_vector_if #(.DATA_SIZE(DATA_SIZE)) key_vec ();
  dnc_vector_if #(.DATA_SIZE(DATA_SIZE)) row_vec ();

  ////////////////////
  // Blocks
  ////////////////////

  dnc_write_key #(
    .DATA_SIZE(DATA_SIZE)
  ) dnc_write_key_inst (
    .CLK        (CLK),
    .RST        (RST),
    .begin_pulse(begin_pulse),
    .size_w     (size_w_req),
    .key_valid  (key_valid),
    .key_ready  (key_ready),
    .key_data   (key_data),
    .key_vec    (key_vec.source)
  );

  dnc_memory_rows #(
    .DATA_SIZE(DATA_SIZE),
    .SIZE_N   (SIZE_N),
    .SIZE_W   (SIZE_W)
  ) dnc_memory_rows_inst (
    .CLK         (CLK),
    .RST         (RST),
    .mem_wr_valid(mem_wr_valid),
    .mem_wr_ready(mem_wr_ready),
    .mem_wr_row  (mem_wr_row),
    .mem_wr_col  (mem_wr_col),
    .mem_wr_data (mem_wr_data),
    .begin_pulse (begin_pulse),
    .row_sel     (row_sel),
    .size_w      (size_w_req),
    .row_vec     (row_vec.source)
  );

  dnc_content_score #(
    .DATA_SIZE(DATA_SIZE),
    .SIZE_N   (SIZE_N)
  ) dnc_content_score_inst (
    .CLK        (CLK),
    .RST        (RST),
    .start_valid(start_valid),
    .start_ready(start_ready),
    .start_row  (start_row),
    .size_w_in  (size_w),
    .begin_pulse(begin_pulse),
    .size_w     (size_w_req),
    .row_sel    (row_sel),
    .key_vec    (key_vec.sink),
    .row_vec    (row_vec.sink),
    .score_valid(score_valid),
    .score_ready(score_ready),
    .score_data (score_data)
  );

endmodule

`default_nettype wire

/* design/dnc_content_score.sv */
/*
  Content scorer
  Owns the request, starts both streamers and sums key times row
  products into one wrapping score
*/
`timescale 1ns/1ps
`default_nettype none

module dnc_content_score #(
  parameter int DATA_SIZE = 16,
  parameter int SIZE_N    = 8
) (
  input  wire                                         CLK,
  input  wire                                         RST,

  // Request
  input  wire                                         start_valid,
  output logic                                        start_ready,
  input  wire  [$clog2(SIZE_N)-1:0]                   start_row,
  input  wire  [dnc_pkg::CNT_SIZE-1:0]                size_w_in,

  // Toward both streamers
  output logic                                        begin_pulse,
  output logic [dnc_pkg::CNT_SIZE-1:0]                size_w,
  output logic [$clog2(SIZE_N)-1:0]                   row_sel,

  // Paired element streams
  dnc_vector_if.sink                                  key_vec,
  dnc_vector_if.sink                                  row_vec,

  // Result
  output logic                                        score_valid,
  input  wire                                         score_ready,
  output logic [2*DATA_SIZE+dnc_pkg::ACC_GUARD-1:0]   score_data
);

  import dnc_pkg::*;

  // Product width plus guard
  localparam int SCORE_SIZE = 2 * DATA_SIZE + ACC_GUARD;

  ////////////////////
  // States
  ////////////////////

  localparam logic [1:0] IDLE_STATE = 2'd0;
  localparam logic [1:0] RUN_STATE  = 2'd1;
  localparam logic [1:0] HOLD_STATE = 2'd2;

  ////////////////////
  // Signals
  ////////////////////

  logic [1:0]                    state;
  logic                          start_take;
  logic                          score_take;
  logic                          pair;
  logic                          pair_last;
  logic signed [2*DATA_SIZE-1:0] product;
  logic signed [SCORE_SIZE-1:0]  acc;
  logic signed [SCORE_SIZE-1:0]  acc_next;

  assign start_take = start_valid && start_ready;
  assign score_take = score_valid && score_ready;

  // Pairs only move together
  assign pair          = key_vec.valid && row_vec.valid;
  assign key_vec.ready = pair;
  assign row_vec.ready = pair;

  // Both streams tag element W-1
  assign pair_last = pair && key_vec.last && row_vec.last;

  ////////////////////
  // Multiply-accumulate
  ////////////////////

  assign product  = $signed(key_vec.data) * $signed(row_vec.data);

  // Sign extended, wraps at SCORE_SIZE
  assign acc_next = acc + SCORE_SIZE'(product);

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= IDLE_STATE;
      start_ready <= 1'b0;
      begin_pulse <= 1'b0;
      score_valid <= 1'b0;
    end else begin
      // Single cycle strobe
      begin_pulse <= 1'b0;
      case (state)
        IDLE_STATE: begin
          if (start_take) begin
            start_ready <= 1'b0;
            begin_pulse <= 1'b1;
            state       <= RUN_STATE;
          end else begin
            start_ready <= 1'b1;
          end
        end
        RUN_STATE: begin
          if (pair_last) begin
            score_valid <= 1'b1;
            state       <= HOLD_STATE;
          end
        end
        HOLD_STATE: begin
          // Held until taken
          if (score_take) begin
            score_valid <= 1'b0;
            start_ready <= 1'b1;
            state       <= IDLE_STATE;
          end
        end
        default: begin
          state <= IDLE_STATE;
        end
      endcase
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge CLK) begin
    // Request fields stay put for the whole request
    if (start_take) begin
      row_sel <= start_row;
      size_w  <= size_w_in;
    end

    // Sum restarts with each request
    if (begin_pulse) begin
      acc <= '0;
    end else if (pair) begin
      acc <= acc_next;
    end

    // Final pair included
    if (pair_last) begin
      score_data <= acc_next;
    end
  end

endmodule

`default_nettype wire

/* design/dnc_memory_rows.sv */
/*
  Memory row store
  SIZE_N by SIZE_W register file with an element write port
  Streams the first W elements of the selected row after begin
*/
`timescale 1ns/1ps
`default_nettype none

module dnc_memory_rows #(
  parameter int DATA_SIZE = 16,
  parameter int SIZE_N    = 8,
  parameter int SIZE_W    = 8
) (
  input  wire                          CLK,
  input  wire                          RST,

  // Element write port
  input  wire                          mem_wr_valid,
  output logic                         mem_wr_ready,
  input  wire  [$clog2(SIZE_N)-1:0]    mem_wr_row,
  input  wire  [dnc_pkg::CNT_SIZE-1:0] mem_wr_col,
  input  wire  [DATA_SIZE-1:0]         mem_wr_data,

  // Request from the scorer
  input  wire                          begin_pulse,
  input  wire  [$clog2(SIZE_N)-1:0]    row_sel,
  input  wire  [dnc_pkg::CNT_SIZE-1:0] size_w,

  // Row stream toward the scorer
  dnc_vector_if.source                 row_vec
);

  import dnc_pkg::*;

  // Column index bits into the storage
  localparam int COL_BITS = (SIZE_W > 1) ? $clog2(SIZE_W) : 1;

  ////////////////////
  // Signals
  ////////////////////

  logic [DATA_SIZE-1:0] mem [SIZE_N][SIZE_W];

  logic                 wr_enable;
  logic                 wr_accept;
  logic                 wr_in_range;
  logic                 row_take;
  logic                 load;
  logic [CNT_SIZE-1:0]  col;
  logic [CNT_SIZE-1:0]  rd_col;

  ////////////////////
  // Write side
  ////////////////////

  // Closed from begin until the last row element leaves
  assign mem_wr_ready = wr_enable && !begin_pulse && !row_vec.valid;
  assign wr_accept    = mem_wr_valid && mem_wr_ready;

  // Out of range writes are dropped
  assign wr_in_range  = (mem_wr_col < CNT_SIZE'(SIZE_W)) && (32'(mem_wr_row) < SIZE_N);

  ////////////////////
  // Read side
  ////////////////////

  assign row_take = row_vec.valid && row_vec.ready;

  // New element on begin or after a non-final transfer
  assign load     = begin_pulse || (row_take && !row_vec.last);
  assign rd_col   = begin_pulse ? '0 : col;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_enable     <= 1'b0;
      col           <= '0;
      row_vec.valid <= 1'b0;
      row_vec.last  <= 1'b0;
      for (int r = 0; r < SIZE_N; r++) begin
        for (int c = 0; c < SIZE_W; c++) begin
          mem[r][c] <= '0;
        end
      end
    end else begin
      // Write port opens one clock out of reset
      wr_enable <= 1'b1;

      if (wr_accept && wr_in_range) begin
        mem[mem_wr_row][mem_wr_col[COL_BITS-1:0]] <= mem_wr_data;
      end

      if (begin_pulse) begin
        // Element 0 goes out next cycle
        row_vec.valid <= 1'b1;
        row_vec.last  <= (size_w == CNT_SIZE'(1));
        col           <= CNT_SIZE'(1);
      end else if (row_take) begin
        if (row_vec.last) begin
          // Row finished
          row_vec.valid <= 1'b0;
          row_vec.last  <= 1'b0;
        end else begin
          row_vec.last <= (col == (size_w - CNT_SIZE'(1)));
          col          <= col + CNT_SIZE'(1);
        end
      end
    end
  end

  // M(t-1)[row][col]
  always_ff @(posedge CLK) begin
    if (load) begin
      row_vec.data <= mem[row_sel][rd_col[COL_BITS-1:0]];
    end
  end

endmodule

`default_nettype wire

/* design/dnc_write_key.sv */
/*
  Write key streamer
  Accepts W key elements per request and forwards them on the key stream,
  tagging the final element with last
*/
`timescale 1ns/1ps
`default_nettype none

module dnc_write_key #(
  parameter int DATA_SIZE = 16
) (
  input  wire                          CLK,
  input  wire                          RST,

  // Request from the scorer
  input  wire                          begin_pulse,
  input  wire  [dnc_pkg::CNT_SIZE-1:0] size_w,

  // Key input
  input  wire                          key_valid,
  output logic                         key_ready,
  input  wire  [DATA_SIZE-1:0]         key_data,

  // Key stream toward the scorer
  dnc_vector_if.source                 key_vec
);

  import dnc_pkg::*;

  ////////////////////
  // States
  ////////////////////

  localparam logic IDLE_STATE = 1'b0;
  localparam logic RUN_STATE  = 1'b1;

  ////////////////////
  // Signals
  ////////////////////

  logic                state;
  logic [CNT_SIZE-1:0] index_loop;
  logic [CNT_SIZE-1:0] index_cur;
  logic                active;
  logic                out_free;
  logic                accept;
  logic                at_last;

  ////////////////////
  // Handshake
  ////////////////////

  // Open from the begin cycle until W elements are in
  assign active    = begin_pulse || (state == RUN_STATE);

  // Output register empty or draining this cycle
  assign out_free  = !key_vec.valid || key_vec.ready;

  assign key_ready = active && out_free;
  assign accept    = key_valid && key_ready;

  // Index restarts on begin
  assign index_cur = begin_pulse ? '0 : index_loop;
  assign at_last   = (index_cur == (size_w - CNT_SIZE'(1)));

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state         <= IDLE_STATE;
      index_loop    <= '0;
      key_vec.valid <= 1'b0;
      key_vec.last  <= 1'b0;
    end else begin
      if (accept) begin
        // Element moves into the output register
        key_vec.valid <= 1'b1;
        key_vec.last  <= at_last;
        if (at_last) begin
          // All W taken
          state <= IDLE_STATE;
        end else begin
          state      <= RUN_STATE;
          index_loop <= index_cur + CNT_SIZE'(1);
        end
      end else begin
        // Register drained with nothing new behind it
        if (key_vec.ready) begin
          key_vec.valid <= 1'b0;
        end
        // Request arrived but no element yet
        if (begin_pulse) begin
          state      <= RUN_STATE;
          index_loop <= '0;
        end
      end
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  // k(t) taken as given, no transform here
  always_ff @(posedge CLK) begin
    if (accept) begin
      key_vec.data <= key_data;
    end
  end

endmodule

`default_nettype wire

/* design/dnc_vector_if.sv */
/*
  Element stream between the write head blocks
  One element moves per valid/ready transfer, last tags the final one
*/
`timescale 1ns/1ps
`default_nettype none

interface dnc_vector_if #(
  parameter int DATA_SIZE = 16
) ();

  // Handshake
  logic                 valid;
  logic                 ready;

  // Final element of the vector
  logic                 last;

  // Element payload
  logic [DATA_SIZE-1:0] data;

  // Producer side
  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

/* design/dnc_pkg.sv */
/*
  Shared constants for the content-addressing front end
  Counter widths and accumulator headroom
*/
`default_nettype none

package dnc_pkg;

  ////////////////////
  // Counters
  ////////////////////

  // Width of element counters and of the W field
  localparam int CNT_SIZE = 8;

  ////////////////////
  // Accumulator
  ////////////////////

  // Guard bits above the product width
  // 256 products fit before the sum can wrap
  localparam int ACC_GUARD = 8;

endpackage

`default_nettype wire

/* include/dnc_defaults.svh */
/*
  Default sizes for the content-addressing write head
  Shared by the top level and the testbench
*/
`ifndef DNC_DEFAULTS_SVH
`define DNC_DEFAULTS_SVH

// Signed element width
`define DNC_DATA_SIZE 16
// Memory rows
`define DNC_SIZE_N 8
// Elements per row
`define DNC_SIZE_W 8

`endif
